// ==== vlog.f ====
+incdir+.
src/bpStatePkg.sv
src/bpPortPkg.sv
src/foldedIndexHash.sv
src/phtBank.sv
src/predictionMerge.sv
src/historyRegister.sv
src/gshareTop.sv
verif/gshare_chk.sv
verif/gshareMonitor.sv
verif/gshareTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the gshare testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module gshareTb -o simv \
  > build.log 2>&1 \
  && ./obj_dir/simv > sim.log 2>&1 \
  || echo "Build or simulation returned an error"
grep -q "=== PASS ===" sim.log && echo "Simulation passed" && exit 0 \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== verif/gshareTb.sv ====
// Gshare predictor testbench
// Clock, reset and a table of lookups and resolves applied in a loop.
// The monitor holds the reference model and does the comparing;
// this module reports per test and gives the final verdict.

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module gshareTb;

  // Lookup PCs with known folded indices under a zero history
  localparam logic [31:0] pcA = 32'h0000_1000;
  localparam logic [31:0] pcB = 32'h0000_3000;

  // One stimulus row, expCtr of 4 means no table expectation
  typedef struct packed {
    logic [7:0]              test;
    logic                    lkValid;
    logic                    lkRand;
    logic [31:0]             lkPc;
    logic [2:0]              expCtr;
    logic                    resValid;
    logic [31:0]             resPc;
    logic [`BP_GHR_BITS-1:0] resSnap;
    logic                    resTaken;
    logic                    resMisp;
    logic [3:0]              gap;
  } stimRowT;

  logic                  clk;
  logic                  reset;
  bpPortPkg::lookupReqT  lookup;
  bpPortPkg::resolveT    resolve;
  bpPortPkg::predictionT prediction;
  logic [2:0]            expCtr;
  int                    errors;
  int                    checks;
  int                    pending;
  stimRowT               rows [$];

  gshareTop i_gshareTop (
    .clk        (clk),
    .reset      (reset),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction)
  );

  gshareMonitor i_gshareMonitor (
    .clk        (clk),
    .reset      (reset),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction),
    .expCtr     (expCtr),
    .errors     (errors),
    .checks     (checks),
    .pending    (pending)
  );

  bind gshareTop gshare_chk i_gshareChk (
    .clk         (clk),
    .reset       (reset),
    .lookupValid (lookup.valid),
    .predValid   (prediction.valid),
    .history     (history)
  );

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic addRow(input int test, input int lkValid, input int lkRand,
                        input logic [31:0] lkPc, input int expC, input int resValid,
                        input logic [31:0] resPc, input logic [`BP_GHR_BITS-1:0] resSnap,
                        input int resTaken, input int resMisp, input int gap);
    stimRowT r;
    r.test     = 8'(test);
    r.lkValid  = 1'(lkValid);
    r.lkRand   = 1'(lkRand);
    r.lkPc     = lkPc;
    r.expCtr   = 3'(expC);
    r.resValid = 1'(resValid);
    r.resPc    = resPc;
    r.resSnap  = resSnap;
    r.resTaken = 1'(resTaken);
    r.resMisp  = 1'(resMisp);
    r.gap      = 4'(gap);
    rows.push_back(r);
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  // Columns: test, lookup valid, random pc, pc, expected counter,
  // resolve valid, resolve pc, snapshot, taken, mispredict, idle gap
  task automatic buildTable();
    // Fresh table reads weakly not taken
    addRow(1, 1, 0, pcA, 1, 0, 0, 12'h000, 0, 0, 0);
    addRow(1, 1, 0, 32'h100, 1, 0, 0, 12'h000, 0, 0, 0);
    addRow(1, 1, 0, 32'h300, 1, 0, 0, 12'h000, 0, 0, 0);
    // Train up, saturate, step down, restore wins over shift
    addRow(2, 0, 0, 0, 4, 1, pcA, 12'h000, 1, 0, 0);
    addRow(2, 0, 0, 0, 4, 1, pcA, 12'h000, 1, 0, 0);
    addRow(2, 1, 0, pcA, 3, 0, 0, 12'h000, 0, 0, 0);
    addRow(2, 0, 0, 0, 4, 1, pcA, 12'h000, 1, 0, 0);
    addRow(2, 0, 0, 0, 4, 1, pcA, 12'h000, 0, 1, 1);
    addRow(2, 1, 0, pcA, 2, 0, 0, 12'h000, 0, 0, 1);
    addRow(2, 0, 0, 0, 4, 1, pcA, 12'h000, 0, 1, 0);
    addRow(2, 1, 0, pcA, 1, 0, 0, 12'h000, 0, 0, 0);
    // Same PC under history 1 hits a separate entry
    addRow(3, 0, 0, 0, 4, 1, pcB, 12'h000, 1, 1, 0);
    addRow(3, 1, 0, pcA, 1, 0, 0, 12'h000, 0, 0, 0);
    addRow(3, 0, 0, 0, 4, 1, pcA, 12'h001, 1, 0, 0);
    addRow(3, 0, 0, 0, 4, 1, pcA, 12'h001, 1, 0, 0);
    addRow(3, 0, 0, 0, 4, 1, pcB, 12'h000, 1, 1, 0);
    addRow(3, 1, 0, pcA, 3, 0, 0, 12'h000, 0, 0, 2);
    addRow(3, 0, 0, 0, 4, 1, pcB, 12'h000, 0, 1, 0);
    addRow(3, 1, 0, pcA, 1, 0, 0, 12'h000, 0, 0, 0);
    // Taken predictions shift ones in, then a repair from a wide snapshot
    addRow(4, 0, 0, 0, 4, 1, pcB, 12'h000, 1, 1, 0);
    addRow(4, 1, 0, pcA, 3, 0, 0, 12'h000, 0, 0, 2);
    addRow(4, 1, 0, pcA, 1, 0, 0, 12'h000, 0, 0, 0);
    addRow(4, 0, 0, 0, 4, 1, pcA, 12'h0ab, 1, 1, 1);
    addRow(4, 1, 0, pcA, 4, 0, 0, 12'h000, 0, 0, 1);
    addRow(4, 0, 0, 0, 4, 1, pcB, 12'h000, 0, 1, 0);
    // Lookup and training of one row in the same cycle
    addRow(5, 1, 0, pcA, 2, 1, pcA, 12'h000, 1, 0, 2);
    addRow(5, 0, 0, 0, 4, 1, pcB, 12'h000, 0, 1, 0);
    // Back to back over all four banks, then random filler
    addRow(6, 1, 0, pcA, 4, 0, 0, 12'h000, 0, 0, 0);
    addRow(6, 1, 0, 32'h100, 4, 0, 0, 12'h000, 0, 0, 0);
    addRow(6, 1, 0, 32'h200, 4, 0, 0, 12'h000, 0, 0, 0);
    addRow(6, 1, 0, 32'h300, 4, 0, 0, 12'h000, 0, 0, 0);
    addRow(6, 1, 1, 0, 4, 1, pcA, 12'h000, 0, 0, 0);
    addRow(6, 1, 1, 0, 4, 0, 0, 12'h000, 0, 0, 0);
    addRow(6, 1, 1, 0, 4, 1, pcB, 12'h000, 1, 1, 0);
  endtask

  task automatic driveIdle();
    lookup  = '0;
    resolve = '0;
    expCtr  = 3'd4;
  endtask

  task automatic applyRow(input stimRowT r);
    lookup.valid       = r.lkValid;
    lookup.pc          = r.lkRand ? ($urandom() & 32'h0000_3ffc) : r.lkPc;
    expCtr             = r.expCtr;
    resolve.valid      = r.resValid;
    resolve.pc         = r.resPc;
    resolve.snapshot   = r.resSnap;
    resolve.taken      = r.resTaken;
    resolve.mispredict = r.resMisp;
  endtask

  // Wait until every lookup has been compared
  task automatic waitDrain(output bit drained);
    int n;
    n = 0;
    while (pending != 0 && n < 20) begin
      @(posedge clk);
      #1;
      n++;
    end
    drained = (pending == 0);
  endtask

  initial begin
    int  i;
    int  curTest;
    int  errBefore;
    int  testsRun;
    bit  timedOut;
    bit  drained;
    void'($urandom(32'hdb8b5b24));
    driveIdle();
    reset = 1'b1;
    buildTable();
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    i        = 0;
    testsRun = 0;
    timedOut = 1'b0;
    while (i < rows.size() && !timedOut) begin
      curTest   = int'(rows[i].test);
      errBefore = errors;
      while (i < rows.size() && int'(rows[i].test) == curTest) begin
        @(posedge clk);
        #1 applyRow(rows[i]);
        repeat (rows[i].gap) begin
          @(posedge clk);
          #1 driveIdle();
        end
        i++;
      end
      @(posedge clk);
      #1 driveIdle();
      waitDrain(drained);
      if (!drained) begin
        $display("Test %0d timed out with predictions still outstanding", curTest);
        timedOut = 1'b1;
      end
      $display("Test %0d finished with %0d errors", curTest, errors - errBefore);
      testsRun++;
    end
    $display("Summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
    if (errors == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/gshareMonitor.sv ====
// Gshare reference monitor
// Models the PHT and speculative history from the DUT inputs,
// predicts every result two edges after its lookup and compares
// it with the DUT output. Counts checks, errors and open lookups.

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module gshareMonitor (
  input  logic                  clk,
  input  logic                  reset,
  input  bpPortPkg::lookupReqT  lookup,
  input  bpPortPkg::resolveT    resolve,
  input  bpPortPkg::predictionT prediction,
  input  logic [2:0]            expCtr,
  output int                    errors,
  output int                    checks,
  output int                    pending
);

  // Expected result travelling down the two stage model pipe
  typedef struct packed {
    logic                    valid;
    logic [1:0]              ctr;
    logic [`BP_GHR_BITS-1:0] snap;
    logic [2:0]              exp;
  } expectT;

  // Flat model table over the whole folded index
  logic [1:0]              pht [1 << `BP_INDEX_BITS];
  logic [`BP_GHR_BITS-1:0] ghr;
  expectT                  s1;
  expectT                  s2;
  expectT                  fresh;

  // PC word bits against history with the top 4 bits folded onto the low end
  function automatic logic [7:0] indexOf(input logic [31:0] pc, input logic [11:0] hist);
    logic [11:0] mixed;
    mixed = hist ^ pc[13:2];
    return mixed[7:0] ^ {4'h0, mixed[11:8]};
  endfunction

  // Saturating step toward the outcome
  function automatic logic [1:0] nextCtr(input logic [1:0] c, input logic taken);
    if (taken) begin
      return (c == 2'd3) ? c : c + 2'd1;
    end
    return (c == 2'd0) ? c : c - 2'd1;
  endfunction

  task automatic report(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("MISMATCH %s expected=%h actual=%h", name, exp, got);
    errors++;
  endtask

  always @(posedge clk) begin
    logic [7:0] lkIdx;
    logic [7:0] rsIdx;
    if (reset) begin
      for (int r = 0; r < (1 << `BP_INDEX_BITS); r++) begin
        pht[r] = 2'b01;
      end
      ghr     = '0;
      s1      = '0;
      s2      = '0;
      errors  = 0;
      checks  = 0;
      pending = 0;
    end else begin
      ////////////////////
      // Compare output
      ////////////////////
      if (prediction.valid !== s2.valid) begin
        report("prediction.valid", 32'(s2.valid), 32'(prediction.valid));
      end else if (s2.valid) begin
        checks++;
        if (prediction.counter !== s2.ctr)
          report("prediction.counter", 32'(s2.ctr), 32'(prediction.counter));
        if (prediction.taken !== s2.ctr[1])
          report("prediction.taken", 32'(s2.ctr[1]), 32'(prediction.taken));
        if (prediction.snapshot !== s2.snap)
          report("prediction.snapshot", 32'(s2.snap), 32'(prediction.snapshot));
        // Table value where the row gives one
        if (s2.exp != 3'd4 && prediction.counter !== s2.exp[1:0])
          report("prediction.counter", 32'(s2.exp[1:0]), 32'(prediction.counter));
      end
      // A lookup stays open until the DUT returns its prediction
      if (prediction.valid === 1'b1 && pending > 0) pending--;
      ////////////////////
      // Model update
      ////////////////////
      lkIdx       = indexOf(lookup.pc, ghr);
      rsIdx       = indexOf(resolve.pc, resolve.snapshot);
      fresh.valid = lookup.valid;
      fresh.ctr   = pht[lkIdx];
      // Training in the lookup cycle is seen by the lookup
      if (resolve.valid && rsIdx == lkIdx) fresh.ctr = nextCtr(pht[rsIdx], resolve.taken);
      fresh.snap  = ghr;
      fresh.exp   = expCtr;
      // Repair beats the speculative shift
      if (resolve.valid && resolve.mispredict) begin
        ghr = {resolve.snapshot[10:0], resolve.taken};
      end else if (s2.valid) begin
        ghr = {ghr[10:0], s2.ctr[1]};
      end
      if (resolve.valid) pht[rsIdx] = nextCtr(pht[rsIdx], resolve.taken);
      s2 = s1;
      s1 = fresh;
      if (lookup.valid) pending++;
    end
  end

endmodule

`default_nettype wire

// ==== verif/gshare_chk.sv ====
// Gshare protocol assertions
// Bound into the top level; checks prediction timing against
// lookups and the reset state of the valid bit and history

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module gshare_chk (
  input logic            clk,
  input logic            reset,
  input logic            lookupValid,
  input logic            predValid,
  input bpStatePkg::ghrT history
);

  // Reset clears the prediction valid bit
  assert property (@(posedge clk) reset |=> !predValid)
    else $error("prediction valid high after a reset cycle");

  // Each lookup yields a prediction two edges later
  assert property (@(posedge clk) disable iff (reset) lookupValid |-> ##2 predValid)
    else $error("lookup without a prediction two cycles later");

  // No prediction without a matching lookup
  assert property (@(posedge clk) disable iff (reset) predValid |-> $past(lookupValid, 2))
    else $error("prediction without a lookup two cycles earlier");

  // History starts from zero
  assert property (@(posedge clk) reset |=> history == '0)
    else $error("history not cleared by reset");

endmodule

`default_nettype wire

// ==== src/gshareTop.sv ====
// Folded gshare direction predictor
// Lookup returns a 2-bit counter prediction with its history snapshot;
// resolve trains the PHT and repairs the speculative history.
// Hash feeds a bank array whose registered reads go to the merge stage.

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module gshareTop (
  input  logic                  clk,
  input  logic                  reset,
  input  bpPortPkg::lookupReqT  lookup,
  input  bpPortPkg::resolveT    resolve,
  output bpPortPkg::predictionT prediction
);

  bpPortPkg::bankReqT      bankReq  [`BP_BANKS];
  bpStatePkg::counterT     counters [`BP_BANKS];
  bpStatePkg::foldedIndexT lookupSel;
  bpStatePkg::ghrT         history;

  // Index hash and bank routing
  foldedIndexHash i_foldedIndexHash (
    .clk       (clk),
    .reset     (reset),
    .lookup    (lookup),
    .resolve   (resolve),
    .history   (history),
    .bankReq   (bankReq),
    .lookupSel (lookupSel)
  );

  ////////////////////
  // PHT banks
  ////////////////////

  for (genvar b = 0; b < `BP_BANKS; b++) begin : g_bank
    phtBank i_phtBank (
      .clk     (clk),
      .reset   (reset),
      .req     (bankReq[b]),
      .counter (counters[b])
    );
  end

  // Bank select and output register
  predictionMerge i_predictionMerge (
    .clk         (clk),
    .reset       (reset),
    .counters    (counters),
    .lookupSel   (lookupSel),
    .lookupValid (lookup.valid),
    .snapshot    (history),
    .prediction  (prediction)
  );

  // Speculative history
  historyRegister i_historyRegister (
    .clk       (clk),
    .reset     (reset),
    .predTaken (prediction.taken),
    .predValid (prediction.valid),
    .resolve   (resolve),
    .history   (history)
  );

endmodule

`default_nettype wire

// ==== src/historyRegister.sv ====
// Speculative global history register
// Shifts in each valid prediction's direction and is repaired
// from a mispredicted resolve, repair winning over a shift

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module historyRegister (
  input  logic               clk,
  input  logic               reset,
  input  logic               predTaken,
  input  logic               predValid,
  input  bpPortPkg::resolveT resolve,
  output bpStatePkg::ghrT    history
);

  bpStatePkg::ghrT historyNext;
  logic            restore;

  ////////////////////
  // Next history
  ////////////////////

  assign restore = resolve.valid && resolve.mispredict;

  always_comb begin
    if (restore) begin
      // Snapshot plus the actual outcome
      historyNext = {resolve.snapshot[`BP_GHR_BITS-2:0], resolve.taken};
    end else if (predValid) begin
      // Speculative shift of the predicted direction
      historyNext = {history[`BP_GHR_BITS-2:0], predTaken};
    end else begin
      historyNext = history;
    end
  end

  ////////////////////
  // Register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      history <= '0;
    end else begin
      history <= historyNext;
    end
  end

endmodule

`default_nettype wire

// ==== src/predictionMerge.sv ====
// Prediction merge
// Picks the addressed bank's counter and registers the prediction
// together with the history snapshot of its lookup

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module predictionMerge (
  input  logic                    clk,
  input  logic                    reset,
  input  bpStatePkg::counterT     counters [`BP_BANKS],
  input  bpStatePkg::foldedIndexT lookupSel,
  input  logic                    lookupValid,
  input  bpStatePkg::ghrT         snapshot,
  output bpPortPkg::predictionT   prediction
);

  // Bank read stage, aligned with the bank registers
  logic            validQ;
  bpStatePkg::ghrT snapQ;

  // Output stage
  logic                predValidQ;
  bpStatePkg::counterT predCounterQ;
  bpStatePkg::ghrT     predSnapQ;

  // Valid pipeline
  always_ff @(posedge clk) begin
    if (reset) begin
      validQ     <= 1'b0;
      predValidQ <= 1'b0;
    end else begin
      validQ     <= lookupValid;
      predValidQ <= validQ;
    end
  end

  // Snapshot follows its lookup, counter taken from the selected bank
  always_ff @(posedge clk) begin
    if (lookupValid) begin
      snapQ <= snapshot;
    end
    if (validQ) begin
      predCounterQ <= counters[lookupSel.bank];
      predSnapQ    <= snapQ;
    end
  end

  // Direction is the counter's upper bit
  assign prediction = '{valid:    predValidQ,
                        counter:  predCounterQ,
                        taken:    predCounterQ[1],
                        snapshot: predSnapQ};

endmodule

`default_nettype wire

// ==== src/phtBank.sv ====
// PHT bank
// Array of 2-bit saturating counters with a registered read port
// and a read-modify-write training port. A same-row write in the
// read cycle is forwarded into the read register.

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module phtBank (
  input  logic                clk,
  input  logic                reset,
  input  bpPortPkg::bankReqT  req,
  output bpStatePkg::counterT counter
);

  localparam int rows = 1 << `BP_ROW_BITS;

  bpStatePkg::counterT phtRows [rows];
  bpStatePkg::counterT trained;

  // One step toward the outcome, saturating at both ends
  function automatic bpStatePkg::counterT stepCounter(
    input bpStatePkg::counterT old,
    input logic                taken
  );
    bpStatePkg::counterT stepped;
    case (old)
      bpStatePkg::strongNotTaken: stepped = taken ? bpStatePkg::weakNotTaken
                                                  : bpStatePkg::strongNotTaken;
      bpStatePkg::weakNotTaken:   stepped = taken ? bpStatePkg::weakTaken
                                                  : bpStatePkg::strongNotTaken;
      bpStatePkg::weakTaken:      stepped = taken ? bpStatePkg::strongTaken
                                                  : bpStatePkg::weakNotTaken;
      default:                    stepped = taken ? bpStatePkg::strongTaken
                                                  : bpStatePkg::weakTaken;
    endcase
    return stepped;
  endfunction

  // Trained value of the write row
  assign trained = stepCounter(phtRows[req.wrRow], req.outcome);

  ////////////////////
  // Table and read
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      // All entries start weakly not taken
      for (int r = 0; r < rows; r++) begin
        phtRows[r] <= bpStatePkg::weakNotTaken;
      end
      counter <= bpStatePkg::weakNotTaken;
    end else begin
      if (req.wrEn) begin
        phtRows[req.wrRow] <= trained;
      end
      // Forward training to a read of the same row
      if (req.rdEn) begin
        counter <= (req.wrEn && (req.wrRow == req.rdRow)) ? trained : phtRows[req.rdRow];
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/foldedIndexHash.sv ====
// Folded gshare index hash
// XORs PC bits with global history, folds the upper history bits
// into the index and routes lookup and training to the PHT banks.
// The lookup's index is held for the merge stage.

`timescale 1ns/1ps
`default_nettype none

`include "bp_settings.svh"

module foldedIndexHash (
  input  logic                   clk,
  input  logic                   reset,
  input  bpPortPkg::lookupReqT   lookup,
  input  bpPortPkg::resolveT     resolve,
  input  bpStatePkg::ghrT        history,
  output bpPortPkg::bankReqT     bankReq [`BP_BANKS],
  output bpStatePkg::foldedIndexT lookupSel
);

  // Zero pad for the folded upper bits
  localparam int foldPad = 2 * `BP_INDEX_BITS - `BP_GHR_BITS;

  bpStatePkg::foldedIndexT lookupIdx;
  bpStatePkg::foldedIndexT resolveIdx;

  // PC word bits 13..2 against history, then fold top bits down
  function automatic bpStatePkg::foldedIndexT hashIndex(
    input logic [`BP_PC_BITS-1:0] pc,
    input bpStatePkg::ghrT        ghr
  );
    logic [`BP_GHR_BITS-1:0]   mixed;
    logic [`BP_INDEX_BITS-1:0] folded;
    mixed  = ghr ^ pc[`BP_GHR_BITS+1:2];
    folded = mixed[`BP_INDEX_BITS-1:0] ^
             {{foldPad{1'b0}}, mixed[`BP_GHR_BITS-1:`BP_INDEX_BITS]};
    return bpStatePkg::foldedIndexT'(folded);
  endfunction

  ////////////////////
  // Index formation
  ////////////////////

  // Lookup uses the live history
  assign lookupIdx  = hashIndex(lookup.pc, history);
  // Resolve uses its own snapshot so training lands on the predicting entry
  assign resolveIdx = hashIndex(resolve.pc, resolve.snapshot);

  // Bank decode
  always_comb begin
    for (int b = 0; b < `BP_BANKS; b++) begin
      bankReq[b].rdEn    = lookup.valid && (int'(lookupIdx.bank) == b);
      bankReq[b].rdRow   = lookupIdx.row;
      bankReq[b].wrEn    = resolve.valid && (int'(resolveIdx.bank) == b);
      bankReq[b].wrRow   = resolveIdx.row;
      bankReq[b].outcome = resolve.taken;
    end
  end

  // Bank of the read in flight, only moves on a valid lookup
  always_ff @(posedge clk) begin
    if (reset) begin
      lookupSel <= '0;
    end else if (lookup.valid) begin
      lookupSel <= lookupIdx;
    end
  end

endmodule

`default_nettype wire

// ==== src/bpPortPkg.sv ====
// Predictor port and bank traffic types
// Lookup request, prediction result, resolve feedback and per-bank packets

`default_nettype none

`include "bp_settings.svh"

package bpPortPkg;

  // Fetch-side lookup, accepted whenever valid is high
  typedef struct packed {
    logic                   valid;
    logic [`BP_PC_BITS-1:0] pc;
  } lookupReqT;

  // Prediction, one cycle after the bank read
  // Snapshot is the history that formed the index
  typedef struct packed {
    logic                valid;
    bpStatePkg::counterT counter;
    logic                taken;
    bpStatePkg::ghrT     snapshot;
  } predictionT;

  // Resolved branch coming back from execute
  typedef struct packed {
    logic                   valid;
    logic [`BP_PC_BITS-1:0] pc;
    bpStatePkg::ghrT        snapshot;
    logic                   taken;
    logic                   mispredict;
  } resolveT;

  // One bank's read and training request
  typedef struct packed {
    logic                    rdEn;
    logic [`BP_ROW_BITS-1:0] rdRow;
    logic                    wrEn;
    logic [`BP_ROW_BITS-1:0] wrRow;
    logic                    outcome;
  } bankReqT;

endpackage

`default_nettype wire

// ==== src/bpStatePkg.sv ====
// Predictor state types
// 2-bit direction counter, global history vector and folded PHT index

`default_nettype none

`include "bp_settings.svh"

package bpStatePkg;

  // Saturating direction counter
  // Upper bit gives the predicted direction
  typedef enum logic [1:0] {
    strongNotTaken = 2'b00,
    weakNotTaken   = 2'b01,
    weakTaken      = 2'b10,
    strongTaken    = 2'b11
  } counterT;

  // Speculative global history, newest outcome in bit 0
  typedef logic [`BP_GHR_BITS-1:0] ghrT;

  // Folded index, high bits pick the bank, low bits the row
  typedef struct packed {
    logic [`BP_BANK_BITS-1:0] bank;
    logic [`BP_ROW_BITS-1:0]  row;
  } foldedIndexT;

endpackage

`default_nettype wire

// ==== bp_settings.svh ====
// Gshare predictor sizing
// Widths and counts shared by the predictor packages and RTL
// Bank select and row widths follow from the index width and bank count

`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// Fetch address width
`define BP_PC_BITS 32

// Global history length
`define BP_GHR_BITS 12

// Folded PHT index width
`define BP_INDEX_BITS 8

// Number of identical PHT banks
`define BP_BANKS 4

// Derived split of the folded index
`define BP_BANK_BITS $clog2(`BP_BANKS)
`define BP_ROW_BITS (`BP_INDEX_BITS - `BP_BANK_BITS)

`endif
